// File: rename_cfg_pkg.sv
package rename_cfg_pkg;

    // ==================================================
    // Register file and queue sizes
    // ==================================================
    localparam int ARCH_REGS = 32;
    localparam int PREG_NUM  = 48;

    // Physical registers not covered by the identity map
    localparam int FREE_NUM  = PREG_NUM - ARCH_REGS;

    localparam int ROB_SIZE  = 8;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;

    typedef logic [2:0]  rob_idx_t;

    // One bit wider than the index so a full ROB fits
    typedef logic [3:0]  rob_cnt_t;

    // Holds 0 to FREE_NUM inclusive
    typedef logic [4:0]  free_cnt_t;

    typedef logic [31:0] data_t;
    typedef logic [31:0] pc_t;

endpackage

// File: rename_msg_pkg.sv
package rename_msg_pkg;

    import rename_cfg_pkg::*;

    // Instruction from decode
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
    } dec_uop_t;

    // Renamed instruction towards dispatch
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        areg_t    rd;
        logic     has_dest;
        preg_t    rd_preg;
        preg_t    old_preg;
        preg_t    rs1_preg;
        logic     rs1_valid;
        preg_t    rs2_preg;
        logic     rs2_valid;
        rob_idx_t rob_idx;
    } ren_uop_t;

    // Payload kept per ROB slot
    typedef struct packed {
        pc_t   pc;
        areg_t rd;
        logic  has_dest;
        preg_t new_preg;
        preg_t old_preg;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        data_t    value;
        logic     exception;
    } wb_t;

    // Retired instruction, one per cycle at most
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        pc_t      pc;
        areg_t    rd;
        logic     has_dest;
        preg_t    new_preg;
        preg_t    old_preg;
        data_t    value;
        logic     exception;
    } commit_t;

endpackage

// File: map_table.sv
`timescale 1ns/1ps

module map_table
    import rename_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,

    // Source lookups
    input  areg_t rs1,
    input  areg_t rs2,
    output preg_t rs1_preg,
    output preg_t rs2_preg,

    // Destination lookup gives the mapping being replaced
    input  areg_t rd,
    output preg_t old_preg,

    input  logic  wr_en,
    input  areg_t wr_rd,
    input  preg_t wr_preg
);

    preg_t map_q [ARCH_REGS];

    assign rs1_preg = map_q[rs1];
    assign rs2_preg = map_q[rs2];
    assign old_preg = map_q[rd];

    // ==================================================
    // Map update
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (flush) begin
            // Back to the identity map
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (wr_en) begin
            map_q[wr_rd] <= wr_preg;
        end
    end

endmodule

// File: free_list.sv
`timescale 1ns/1ps

module free_list
    import rename_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,

    // Allocation side
    input  logic  pop,
    output preg_t head_preg,
    output logic  empty,

    // Release side, fed by commit
    input  logic  push,
    input  preg_t push_preg
);

    preg_t     slot_q [FREE_NUM];
    logic [$clog2(FREE_NUM)-1:0] head;
    logic [$clog2(FREE_NUM)-1:0] tail;
    free_cnt_t count;
    logic      do_pop;
    logic      do_push;

    function automatic logic [$clog2(FREE_NUM)-1:0] next_ptr(
        input logic [$clog2(FREE_NUM)-1:0] ptr
    );
        if (ptr == $clog2(FREE_NUM)'(FREE_NUM - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty     = (count == '0);
    assign head_preg = slot_q[head];

    assign do_pop  = pop && !empty;
    assign do_push = push && (count != free_cnt_t'(FREE_NUM));

    // ==================================================
    // Queue state
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FREE_NUM; i++) begin
                slot_q[i] <= preg_t'(ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= free_cnt_t'(FREE_NUM);
        end else if (flush) begin
            // Every register above the identity range is free again
            for (int i = 0; i < FREE_NUM; i++) begin
                slot_q[i] <= preg_t'(ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= free_cnt_t'(FREE_NUM);
        end else begin
            if (do_pop) begin
                head <= next_ptr(head);
            end
            if (do_push) begin
                slot_q[tail] <= push_preg;
                tail         <= next_ptr(tail);
            end
            count <= count + free_cnt_t'(do_push) - free_cnt_t'(do_pop);
        end
    end

endmodule

// File: rob.sv
`timescale 1ns/1ps

module rob
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    // Allocation at the tail
    input  logic       alloc,
    input  rob_entry_t alloc_entry,
    output rob_idx_t   tail_idx,
    output logic       full,

    input  wb_t        wb,

    // Registered in-order retirement
    output commit_t    commit,
    output logic       empty
);

    rob_entry_t entry_q [ROB_SIZE];
    data_t      value_q [ROB_SIZE];
    logic       exc_q   [ROB_SIZE];

    logic [ROB_SIZE-1:0] done_q;
    rob_idx_t   head;
    rob_idx_t   tail;
    rob_cnt_t   count;
    logic       do_alloc;
    logic       do_commit;

    function automatic rob_idx_t next_idx(input rob_idx_t idx);
        if (idx == rob_idx_t'(ROB_SIZE - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == rob_cnt_t'(ROB_SIZE));
    assign tail_idx = tail;

    assign do_alloc  = alloc && !full && !flush;
    // Head retires once its writeback has landed
    assign do_commit = !empty && done_q[head] && !flush;

    // ==================================================
    // Slot payload, value and exception
    // ==================================================
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            entry_q[tail] <= alloc_entry;
        end
        if (wb.valid && !flush) begin
            value_q[wb.rob_idx] <= wb.value;
            exc_q[wb.rob_idx]   <= wb.exception;
        end
    end

    // ==================================================
    // Pointers, done bits and commit port
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
            commit <= '0;
        end else if (flush) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done_q       <= '0;
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= 1'b0;

            if (do_commit) begin
                commit <= '{
                    valid:     1'b1,
                    rob_idx:   head,
                    pc:        entry_q[head].pc,
                    rd:        entry_q[head].rd,
                    has_dest:  entry_q[head].has_dest,
                    new_preg:  entry_q[head].new_preg,
                    old_preg:  entry_q[head].old_preg,
                    value:     value_q[head],
                    exception: exc_q[head]
                };
                done_q[head] <= 1'b0;
                head         <= next_idx(head);
            end

            if (wb.valid) begin
                done_q[wb.rob_idx] <= 1'b1;
            end

            // New entry waits for its own writeback
            if (do_alloc) begin
                done_q[tail] <= 1'b0;
                tail         <= next_idx(tail);
            end

            count <= count + rob_cnt_t'(do_alloc) - rob_cnt_t'(do_commit);
        end
    end

endmodule

// File: rename_stage.sv
`timescale 1ns/1ps

module rename_stage
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  dec_uop_t   in,
    output ren_uop_t   out,
    output logic       stall,

    // Map table lookup and update
    output areg_t      rs1,
    output areg_t      rs2,
    output areg_t      rd,
    input  preg_t      rs1_preg,
    input  preg_t      rs2_preg,
    input  preg_t      old_preg,
    output logic       map_wr,

    // Free list
    input  preg_t      free_head,
    input  logic       free_empty,
    output logic       pop,

    // ROB allocation
    output logic       rob_alloc,
    output rob_entry_t rob_entry,
    input  rob_idx_t   rob_tail,
    input  logic       rob_full
);

    logic     has_dest;
    logic     accept;
    preg_t    new_preg;
    ren_uop_t next_uop;

    // x0 is never renamed
    assign has_dest = (in.rd != '0);

    assign stall  = in.valid && (rob_full || (has_dest && free_empty));
    assign accept = in.valid && !stall && !flush;

    assign rs1 = in.rs1;
    assign rs2 = in.rs2;
    assign rd  = in.rd;

    assign new_preg = has_dest ? free_head : '0;

    assign pop       = accept && has_dest;
    assign map_wr    = accept && has_dest;
    assign rob_alloc = accept;

    assign rob_entry = '{
        pc:       in.pc,
        rd:       in.rd,
        has_dest: has_dest,
        new_preg: new_preg,
        old_preg: old_preg
    };

    // ==================================================
    // Renamed instruction
    // ==================================================
    always_comb begin
        next_uop           = '0;
        next_uop.valid     = 1'b1;
        next_uop.pc        = in.pc;
        next_uop.rd        = in.rd;
        next_uop.has_dest  = has_dest;
        next_uop.rd_preg   = new_preg;
        next_uop.old_preg  = old_preg;
        next_uop.rs1_preg  = rs1_preg;
        next_uop.rs1_valid = (in.rs1 != '0);
        next_uop.rs2_preg  = rs2_preg;
        next_uop.rs2_valid = (in.rs2 != '0);
        next_uop.rob_idx   = rob_tail;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else if (flush) begin
            out.valid <= 1'b0;
        end else if (accept) begin
            out <= next_uop;
        end else begin
            // Stalled or idle cycle
            out.valid <= 1'b0;
        end
    end

endmodule

// File: rename_core.sv
`timescale 1ns/1ps

module rename_core
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,

    input  dec_uop_t in,
    output ren_uop_t out,
    output logic     stall,

    input  wb_t      wb,
    output commit_t  commit,
    output logic     rob_empty
);

    areg_t      lkp_rs1;
    areg_t      lkp_rs2;
    areg_t      lkp_rd;
    preg_t      rs1_preg;
    preg_t      rs2_preg;
    preg_t      old_preg;
    logic       map_wr;
    preg_t      free_head;
    logic       free_empty;
    logic       pop;
    logic       rob_alloc;
    rob_entry_t rob_entry;
    rob_idx_t   rob_tail;
    logic       rob_full;

    // ==================================================
    // Input side
    // ==================================================
    rename_stage u_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in         (in),
        .out        (out),
        .stall      (stall),
        .rs1        (lkp_rs1),
        .rs2        (lkp_rs2),
        .rd         (lkp_rd),
        .rs1_preg   (rs1_preg),
        .rs2_preg   (rs2_preg),
        .old_preg   (old_preg),
        .map_wr     (map_wr),
        .free_head  (free_head),
        .free_empty (free_empty),
        .pop        (pop),
        .rob_alloc  (rob_alloc),
        .rob_entry  (rob_entry),
        .rob_tail   (rob_tail),
        .rob_full   (rob_full)
    );

    map_table u_map (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .rs1      (lkp_rs1),
        .rs2      (lkp_rs2),
        .rs1_preg (rs1_preg),
        .rs2_preg (rs2_preg),
        .rd       (lkp_rd),
        .old_preg (old_preg),
        .wr_en    (map_wr),
        .wr_rd    (lkp_rd),
        .wr_preg  (free_head)
    );

    // Released register comes from the committed entry
    free_list u_free (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .pop       (pop),
        .head_preg (free_head),
        .empty     (free_empty),
        .push      (commit.valid && commit.has_dest),
        .push_preg (commit.old_preg)
    );

    rob u_rob (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .alloc       (rob_alloc),
        .alloc_entry (rob_entry),
        .tail_idx    (rob_tail),
        .full        (rob_full),
        .wb          (wb),
        .commit      (commit),
        .empty       (rob_empty)
    );

endmodule

// File: rename_core_sva.sv
`timescale 1ns/1ps

module rename_core_sva
    import rename_cfg_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      stall,
    input logic      out_valid,
    input logic      commit_valid,
    input logic      rob_empty,
    input free_cnt_t free_count
);

    // ==================================================
    // ROB and free list invariants
    // ==================================================
    commit_after_empty: assert property (
        @(posedge clk) disable iff (!rst_n) rob_empty |=> !commit_valid
    ) else $error("commit issued from an empty ROB");

    free_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) free_count <= free_cnt_t'(FREE_NUM)
    ) else $error("free list count above its depth");

    // Nothing is consumed while stalled
    no_out_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> !out_valid
    ) else $error("renamed output after a stalled cycle");

endmodule

bind rename_core rename_core_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .out_valid    (out.valid),
    .commit_valid (commit.valid),
    .rob_empty    (rob_empty),
    .free_count   (u_free.count)
);

// File: tb_rename_core.sv
`timescale 1ns/1ps

module tb_rename_core
    import rename_cfg_pkg::*;
    import rename_msg_pkg::*;
();

    localparam int TIMEOUT = 40;

    typedef struct packed {
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        pc_t   pc;
        logic  flush;
    } stim_t;

    logic     clk;
    logic     rst_n;
    logic     flush;
    dec_uop_t in;
    ren_uop_t out;
    logic     stall;
    wb_t      wb;
    commit_t  commit;
    logic     rob_empty;

    // Reference model
    preg_t    ref_map [ARCH_REGS];
    preg_t    ref_free [$];
    ren_uop_t ref_rob [$];
    rob_idx_t pending [$];
    rob_idx_t ref_tail;
    data_t    exp_val [ROB_SIZE];
    logic     exp_exc [ROB_SIZE];

    stim_t       stim [23];
    ren_uop_t    last_out;
    logic [15:0] lfsr = 16'd63175;
    int          errors;
    int          checks;
    int          commits;
    int          mark;

    rename_core dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in        (in),
        .out       (out),
        .stall     (stall),
        .wb        (wb),
        .commit    (commit),
        .rob_empty (rob_empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic void reset_model();
        ref_free.delete();
        ref_rob.delete();
        pending.delete();
        ref_tail = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            ref_map[i] = preg_t'(i);
        end
        for (int i = 0; i < FREE_NUM; i++) begin
            ref_free.push_back(preg_t'(ARCH_REGS + i));
        end
    endfunction

    task automatic check_eq(input string name, input logic [95:0] got,
                            input logic [95:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == mark) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", num, name, errors - mark);
        end
    endtask

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic rename_one(input stim_t s);
        ren_uop_t exp;
        int       waited;
        @(posedge clk);
        in <= '{valid: 1'b1, pc: s.pc, rd: s.rd, rs1: s.rs1, rs2: s.rs2};
        waited = 0;
        @(negedge clk);
        while (stall && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (!stall) else begin
            errors++;
            $display("Instruction at pc %h still stalled after %0d cycles", s.pc, TIMEOUT);
        end
        if (stall) begin
            @(posedge clk);
            in <= '0;
        end else begin
            exp           = '0;
            exp.valid     = 1'b1;
            exp.pc        = s.pc;
            exp.rd        = s.rd;
            exp.has_dest  = (s.rd != '0);
            exp.rd_preg   = exp.has_dest ? ref_free[0] : '0;
            exp.old_preg  = ref_map[s.rd];
            exp.rs1_preg  = ref_map[s.rs1];
            exp.rs1_valid = (s.rs1 != '0);
            exp.rs2_preg  = ref_map[s.rs2];
            exp.rs2_valid = (s.rs2 != '0);
            exp.rob_idx   = ref_tail;
            if (exp.has_dest) begin
                ref_free.delete(0);
                ref_map[s.rd] = exp.rd_preg;
            end
            ref_rob.push_back(exp);
            pending.push_back(ref_tail);
            ref_tail = rob_idx_t'(ref_tail + 1);
            @(posedge clk);
            in <= '0;
            @(negedge clk);
            last_out = out;
            check_eq("out", out, exp);
        end
    endtask

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        reset_model();
        @(negedge clk);
        check_eq("rob_empty", rob_empty, 1);
    endtask

    task automatic run_rows(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (stim[i].flush) begin
                apply_flush();
            end else begin
                rename_one(stim[i]);
            end
        end
    endtask

    // Ninth instruction against a full ROB
    task automatic expect_stall(input stim_t s);
        @(posedge clk);
        in <= '{valid: 1'b1, pc: s.pc, rd: s.rd, rs1: s.rs1, rs2: s.rs2};
        repeat (3) begin
            @(negedge clk);
            check_eq("stall", stall, 1);
            check_eq("out.valid", out.valid, 0);
        end
        @(posedge clk);
        in <= '0;
    endtask

    // Write back every outstanding entry in LFSR order, then wait for the ROB to empty
    task automatic drain();
        logic [31:0] bits;
        rob_idx_t    idx;
        int          k;
        int          waited;
        while (pending.size() > 0) begin
            bits = take_bits(3);
            k    = int'(bits[2:0]) % pending.size();
            idx  = pending[k];
            pending.delete(k);
            exp_val[idx] = take_bits(32);
            bits         = take_bits(1);
            exp_exc[idx] = bits[0];
            @(posedge clk);
            wb <= '{valid: 1'b1, rob_idx: idx, value: exp_val[idx], exception: exp_exc[idx]};
        end
        @(posedge clk);
        wb <= '0;
        waited = 0;
        @(negedge clk);
        while (!rob_empty && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        checks++;
        assert (rob_empty && ref_rob.size() == 0) else begin
            errors++;
            $display("ROB did not drain, %0d commits missing", ref_rob.size());
        end
    endtask

    // ==================================================
    // Commit monitor
    // ==================================================
    always @(negedge clk) begin
        ren_uop_t e;
        commit_t  ec;
        if (rst_n && commit.valid) begin
            checks++;
            assert (ref_rob.size() != 0) else begin
                errors++;
                $display("Commit at %0d ns with no instruction outstanding", $time);
            end
            if (ref_rob.size() != 0) begin
                e  = ref_rob.pop_front();
                ec = '{valid: 1'b1, rob_idx: e.rob_idx, pc: e.pc, rd: e.rd,
                       has_dest: e.has_dest, new_preg: e.rd_preg, old_preg: e.old_preg,
                       value: exp_val[e.rob_idx], exception: exp_exc[e.rob_idx]};
                check_eq("commit", commit, ec);
                commits++;
                if (e.has_dest) begin
                    ref_free.push_back(e.old_preg);
                end
            end
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        in    = '0;
        wb    = '0;
        reset_model();
        // Columns are rd, rs1, rs2, pc and flush
        stim = '{
            '{5'd0,  5'd5,  5'd0,  32'h100, 1'b0},
            '{5'd0,  5'd0,  5'd31, 32'h104, 1'b0},
            '{5'd3,  5'd1,  5'd2,  32'h108, 1'b0},
            '{5'd4,  5'd3,  5'd3,  32'h10c, 1'b0},
            '{5'd3,  5'd3,  5'd4,  32'h110, 1'b0},
            '{5'd7,  5'd3,  5'd4,  32'h200, 1'b0},
            '{5'd0,  5'd7,  5'd0,  32'h204, 1'b0},
            '{5'd8,  5'd7,  5'd7,  32'h208, 1'b0},
            '{5'd7,  5'd8,  5'd1,  32'h20c, 1'b0},
            '{5'd9,  5'd0,  5'd0,  32'h210, 1'b0},
            '{5'd31, 5'd9,  5'd7,  32'h214, 1'b0},
            '{5'd10, 5'd1,  5'd2,  32'h300, 1'b0},
            '{5'd11, 5'd10, 5'd0,  32'h304, 1'b0},
            '{5'd12, 5'd11, 5'd10, 32'h308, 1'b0},
            '{5'd13, 5'd12, 5'd3,  32'h30c, 1'b0},
            '{5'd14, 5'd13, 5'd13, 32'h310, 1'b0},
            '{5'd15, 5'd0,  5'd14, 32'h314, 1'b0},
            '{5'd16, 5'd15, 5'd4,  32'h318, 1'b0},
            '{5'd17, 5'd16, 5'd15, 32'h31c, 1'b0},
            '{5'd5,  5'd1,  5'd2,  32'h400, 1'b0},
            '{5'd6,  5'd5,  5'd0,  32'h404, 1'b0},
            '{5'd0,  5'd0,  5'd0,  32'h000, 1'b1},
            '{5'd5,  5'd5,  5'd6,  32'h408, 1'b0}
        };
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        mark = errors;
        check_eq("out.valid", out.valid, 0);
        check_eq("commit.valid", commit.valid, 0);
        check_eq("stall", stall, 0);
        check_eq("rob_empty", rob_empty, 1);
        run_rows(0, 1);
        drain();
        report_test(1, "reset state and source tags");

        mark = errors;
        run_rows(2, 4);
        drain();
        report_test(2, "destination renaming");

        mark = errors;
        run_rows(5, 10);
        drain();
        report_test(3, "out of order writeback");

        mark = errors;
        run_rows(11, 18);
        expect_stall(stim[11]);
        drain();
        run_rows(11, 18);
        drain();
        // Third pass pops the registers freed by the first
        run_rows(11, 18);
        drain();
        report_test(4, "full ROB stall and register reuse");

        mark = errors;
        run_rows(19, 22);
        check_eq("out.rd_preg", last_out.rd_preg, 32);
        check_eq("out.rs1_preg", last_out.rs1_preg, 5);
        drain();
        report_test(5, "flush recovery");

        $display("checks %0d, errors %0d, commits %0d", checks, errors, commits);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: rename_core.f
rename_cfg_pkg.sv
rename_msg_pkg.sv
map_table.sv
free_list.sv
rob.sv
rename_stage.sv
rename_core.sv
rename_core_sva.sv
tb_rename_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rename_core
FILELIST  ?= rename_core.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
